//--- Makefile
VERILATOR ?= verilator
TOP       ?= tile_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compute_tile.sv
// Compute tile top: instruction memory, register file, ALU and control
`timescale 1ns/1ps

module compute_tile (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // Host load handshake
  input  logic                         load_req_i,
  input  logic [tile_pkg::IMEM_AW-1:0] load_addr_i,
  input  logic [tile_pkg::XLEN-1:0]    load_data_i,
  output logic                         load_ack_o,
  // Host run handshake
  input  logic                         run_req_i,
  output logic                         run_ack_o,
  // Retire trace
  output logic                         trace_valid_o,
  output logic [tile_pkg::IMEM_AW-1:0] trace_pc_o,
  output logic [tile_pkg::XLEN-1:0]    trace_insn_o,
  output logic                         trace_wb_en_o,
  output logic [tile_pkg::REG_AW-1:0]  trace_wb_reg_o,
  output logic [tile_pkg::XLEN-1:0]    trace_wb_data_o
);
  import tile_pkg::*;

  // Fetch path between control and memory
  logic [IMEM_AW-1:0] fetch_addr;
  logic [XLEN-1:0]    fetch_data;

  rf_if  rf_bus ();
  alu_if alu_bus ();

  tile_imem i_imem (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .load_req_i   (load_req_i),
    .load_addr_i  (load_addr_i),
    .load_data_i  (load_data_i),
    .load_ack_o   (load_ack_o),
    .fetch_addr_i (fetch_addr),
    .fetch_data_o (fetch_data)
  );

  tile_regfile i_regfile (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .rf      (rf_bus.regfile)
  );

  tile_alu i_alu (
    .alu (alu_bus.alu)
  );

  tile_ctrl i_ctrl (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .run_req_i       (run_req_i),
    .run_ack_o       (run_ack_o),
    .fetch_addr_o    (fetch_addr),
    .fetch_data_i    (fetch_data),
    .rf              (rf_bus.ctrl),
    .alu             (alu_bus.ctrl),
    .trace_valid_o   (trace_valid_o),
    .trace_pc_o      (trace_pc_o),
    .trace_insn_o    (trace_insn_o),
    .trace_wb_en_o   (trace_wb_en_o),
    .trace_wb_reg_o  (trace_wb_reg_o),
    .trace_wb_data_o (trace_wb_data_o)
  );

endmodule

//--- flist.f
tile_pkg.sv
tile_if.sv
tile_imem.sv
tile_regfile.sv
tile_alu.sv
tile_ctrl.sv
compute_tile.sv
tile_tb.sv

//--- tile_alu.sv
// Tile ALU: combinational add, sub, and, or, xor and shift-left
`timescale 1ns/1ps

module tile_alu (
  alu_if.alu alu
);
  import tile_pkg::*;

  // Shift amount from low 5 bits of b
  logic [4:0] shamt;

  assign shamt = alu.b[4:0];

  always_comb begin
    case (alu.op)
      ALU_ADD: begin
        alu.result = alu.a + alu.b;
      end
      ALU_SUB: begin
        alu.result = alu.a - alu.b;
      end
      ALU_AND: begin
        alu.result = alu.a & alu.b;
      end
      ALU_OR: begin
        alu.result = alu.a | alu.b;
      end
      ALU_XOR: begin
        alu.result = alu.a ^ alu.b;
      end
      ALU_SLL: begin
        alu.result = alu.a << shamt;
      end
      // Unused encodings
      default: begin
        alu.result = '0;
      end
    endcase
  end

endmodule

//--- tile_ctrl.sv
// Tile control: run handshake, fetch/exec sequencing, decode, branch and trace
`timescale 1ns/1ps

module tile_ctrl (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // Host run handshake
  input  logic                         run_req_i,
  output logic                         run_ack_o,
  // Instruction fetch
  output logic [tile_pkg::IMEM_AW-1:0] fetch_addr_o,
  input  logic [tile_pkg::XLEN-1:0]    fetch_data_i,
  // Datapath
  rf_if.ctrl                           rf,
  alu_if.ctrl                          alu,
  // Retire trace
  output logic                         trace_valid_o,
  output logic [tile_pkg::IMEM_AW-1:0] trace_pc_o,
  output logic [tile_pkg::XLEN-1:0]    trace_insn_o,
  output logic                         trace_wb_en_o,
  output logic [tile_pkg::REG_AW-1:0]  trace_wb_reg_o,
  output logic [tile_pkg::XLEN-1:0]    trace_wb_data_o
);
  import tile_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_DONE
  } state_e;

  state_e             state;
  logic [IMEM_AW-1:0] pc;
  logic [IMEM_AW-1:0] pc_next;
  insn_u              insn;
  logic [XLEN-1:0]    imm_sext;
  logic               wb_en;
  logic               is_halt;
  logic               br_taken;

  // Fetched word, valid during EXEC
  assign insn         = fetch_data_i;
  assign fetch_addr_o = pc;
  assign run_ack_o    = (state == ST_DONE);

  assign imm_sext = {{(XLEN-IMM_W){insn.i.imm[IMM_W-1]}}, insn.i.imm};
  assign is_halt  = (insn.r.op == OP_HALT);
  assign br_taken = (insn.r.op == OP_BNEZ) && (rf.rs1_data != '0);
  // Offset truncated to pc width, wraps over IMEM_DEPTH
  assign pc_next  = br_taken ? pc + insn.i.imm[IMEM_AW-1:0] : pc + 1'b1;

  // Decode and operand select
  always_comb begin
    rf.rs1_addr = insn.r.rs1;
    rf.rs2_addr = insn.r.rs2;
    alu.op      = ALU_ADD;
    alu.a       = rf.rs1_data;
    alu.b       = rf.rs2_data;
    wb_en       = 1'b0;
    case (insn.r.op)
      OP_ADD: wb_en = 1'b1;
      OP_SUB: begin
        alu.op = ALU_SUB;
        wb_en  = 1'b1;
      end
      OP_AND: begin
        alu.op = ALU_AND;
        wb_en  = 1'b1;
      end
      OP_OR: begin
        alu.op = ALU_OR;
        wb_en  = 1'b1;
      end
      OP_XOR: begin
        alu.op = ALU_XOR;
        wb_en  = 1'b1;
      end
      OP_SLL: begin
        alu.op = ALU_SLL;
        wb_en  = 1'b1;
      end
      // I-form view, immediate replaces rs2
      OP_ADDI: begin
        alu.b = imm_sext;
        wb_en = 1'b1;
      end
      // Branch and halt write nothing
      OP_BNEZ, OP_HALT: wb_en = 1'b0;
      default: wb_en = 1'b0;
    endcase
  end

  // Writeback lands on the EXEC edge
  assign rf.wr_en   = (state == ST_EXEC) && wb_en;
  assign rf.wr_addr = insn.r.rd;
  assign rf.wr_data = alu.result;

  // Run sequencing, two cycles per instruction
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state <= ST_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (run_req_i) begin
            state <= ST_FETCH;
            pc    <= '0;
          end
        end
        ST_FETCH: state <= ST_EXEC;
        ST_EXEC: begin
          if (is_halt) begin
            state <= ST_DONE;
          end else begin
            state <= ST_FETCH;
            pc    <= pc_next;
          end
        end
        // Ack held until host drops req
        ST_DONE: if (!run_req_i) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // One trace pulse per retired instruction
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trace_valid_o <= 1'b0;
    end else begin
      trace_valid_o <= (state == ST_EXEC);
    end
  end

  // Trace payload, qualified by trace_valid_o
  always_ff @(posedge clk) begin
    if (state == ST_EXEC) begin
      trace_pc_o      <= pc;
      trace_insn_o    <= fetch_data_i;
      trace_wb_en_o   <= wb_en;
      trace_wb_reg_o  <= insn.r.rd;
      trace_wb_data_o <= alu.result;
    end
  end

endmodule

//--- tile_if.sv
// Tile interfaces: register file access and ALU operand/result buses
`timescale 1ns/1ps

interface rf_if;
  import tile_pkg::*;

  // Read addresses from control
  logic [REG_AW-1:0] rs1_addr;
  logic [REG_AW-1:0] rs2_addr;
  // Combinational read data
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  // Single write port
  logic              wr_en;
  logic [REG_AW-1:0] wr_addr;
  logic [XLEN-1:0]   wr_data;

  modport ctrl (
    output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
    input  rs1_data, rs2_data
  );

  modport regfile (
    input  rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
    output rs1_data, rs2_data
  );
endinterface

interface alu_if;
  import tile_pkg::*;

  alu_op_e         op;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  // Zero-latency result
  logic [XLEN-1:0] result;

  modport ctrl (output op, a, b, input result);

  modport alu (input op, a, b, output result);
endinterface

//--- tile_imem.sv
// Instruction memory: host load over req/ack handshake, one-cycle fetch read
`timescale 1ns/1ps

module tile_imem (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // Host load handshake
  input  logic                         load_req_i,
  input  logic [tile_pkg::IMEM_AW-1:0] load_addr_i,
  input  logic [tile_pkg::XLEN-1:0]    load_data_i,
  output logic                         load_ack_o,
  // Core fetch port
  input  logic [tile_pkg::IMEM_AW-1:0] fetch_addr_i,
  output logic [tile_pkg::XLEN-1:0]    fetch_data_o
);
  import tile_pkg::*;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_WRITE,
    LD_ACK
  } ld_state_e;

  logic [XLEN-1:0] mem [IMEM_DEPTH];
  ld_state_e       ld_state;
  logic            ld_write;

  // New request seen, word goes in on this edge
  assign ld_write   = (ld_state == LD_IDLE) && load_req_i;
  // Ack only while in the acknowledge phase
  assign load_ack_o = (ld_state == LD_ACK);

  // Four-phase handshake sequencing
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ld_state <= LD_IDLE;
    end else begin
      case (ld_state)
        LD_IDLE:  if (ld_write) ld_state <= LD_WRITE;
        // One cycle after the write, raise ack
        LD_WRITE: ld_state <= LD_ACK;
        // Hold ack until host drops req
        LD_ACK:   if (!load_req_i) ld_state <= LD_IDLE;
        default:  ld_state <= LD_IDLE;
      endcase
    end
  end

  // Array write and registered fetch read
  always_ff @(posedge clk) begin
    if (ld_write) begin
      mem[load_addr_i] <= load_data_i;
    end
    fetch_data_o <= mem[fetch_addr_i];
  end

endmodule

//--- tile_pkg.sv
// Tile ISA package: word sizes, opcodes, ALU operations and instruction formats
package tile_pkg;

  // Data and instruction word width
  localparam int XLEN = 32;

  // Register file geometry
  localparam int NREGS  = 16;
  localparam int REG_AW = 4;

  // Instruction memory geometry
  localparam int IMEM_DEPTH = 64;
  localparam int IMEM_AW    = 6;

  // I-form immediate, sign-extended to XLEN
  localparam int IMM_W = 20;

  // Instruction opcodes, undefined codes retire as no-ops
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    // Shift amount from low 5 bits of rs2
    OP_SLL  = 4'h5,
    OP_ADDI = 4'h8,
    // pc += imm when rs1 is nonzero
    OP_BNEZ = 4'h9,
    OP_HALT = 4'hf
  } opcode_e;

  // ALU operation select
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5
  } alu_op_e;

  // R-form, register operands only
  typedef struct packed {
    opcode_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [15:0]       unused;
  } insn_r_t;

  // I-form, low 20 bits carry the immediate
  typedef struct packed {
    opcode_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [IMM_W-1:0]  imm;
  } insn_i_t;

  // Same fetched word seen in both views, opcode picks the valid one
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
  } insn_u;

endpackage

//--- tile_regfile.sv
// Register file: sixteen words, two async reads, one write, r0 hardwired to zero
`timescale 1ns/1ps

module tile_regfile (
  input  logic      clk,
  input  logic      rst_n_i,
  rf_if.regfile     rf
);
  import tile_pkg::*;

  logic [XLEN-1:0] regs [NREGS];

  // Clear on reset, drop writes to r0
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wr_en && (rf.wr_addr != '0)) begin
      regs[rf.wr_addr] <= rf.wr_data;
    end
  end

  // Reads see a write the cycle after it
  // r0 forced to zero on both ports
  assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
  assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

endmodule

//--- tile_tb.sv
// Compute tile testbench: loads each program, runs it and checks the trace and r3
`timescale 1ns/1ps

module tile_tb;
  import tile_pkg::*;

  localparam int NROWS    = 6;
  localparam int MAXW     = 8;
  localparam int ACK_WAIT = 8;

  logic               clk;
  logic               rst_n_i;
  logic               load_req_i;
  logic [IMEM_AW-1:0] load_addr_i;
  logic [XLEN-1:0]    load_data_i;
  logic               load_ack_o;
  logic               run_req_i;
  logic               run_ack_o;
  logic               trace_valid_o;
  logic [IMEM_AW-1:0] trace_pc_o;
  logic [XLEN-1:0]    trace_insn_o;
  logic               trace_wb_en_o;
  logic [REG_AW-1:0]  trace_wb_reg_o;
  logic [XLEN-1:0]    trace_wb_data_o;

  // Program table, one row per test
  logic [XLEN-1:0] prog [NROWS][MAXW];
  int              nwords [NROWS];
  logic [XLEN-1:0] exp_r3 [NROWS];
  int              exp_ret [NROWS];
  string           row_name [NROWS];

  logic [31:0]     lfsr;
  int              cyc;
  int              limit;
  int              errors;
  int              row_err;
  int              rows_ok;
  // Shadow of r3, follows trace writebacks across runs
  logic [XLEN-1:0] shadow_r3;

  compute_tile i_dut (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .load_req_i      (load_req_i),
    .load_addr_i     (load_addr_i),
    .load_data_i     (load_data_i),
    .load_ack_o      (load_ack_o),
    .run_req_i       (run_req_i),
    .run_ack_o       (run_ack_o),
    .trace_valid_o   (trace_valid_o),
    .trace_pc_o      (trace_pc_o),
    .trace_insn_o    (trace_insn_o),
    .trace_wb_en_o   (trace_wb_en_o),
    .trace_wb_reg_o  (trace_wb_reg_o),
    .trace_wb_data_o (trace_wb_data_o)
  );

  always #50 clk = ~clk;

  // Cycle count and watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("Timeout: the tests did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Galois step, right shift with feedback mask
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] sext20(input logic [IMM_W-1:0] v);
    return {{(XLEN-IMM_W){v[IMM_W-1]}}, v};
  endfunction

  // R-form word: op, rd, rs1, rs2, zero fill
  function automatic logic [XLEN-1:0] enc_r(input opcode_e op, input int rd, input int rs1,
                                            input int rs2);
    return {op, REG_AW'(rd), REG_AW'(rs1), REG_AW'(rs2), 16'h0};
  endfunction

  // I-form word: op, rd, rs1, 20-bit immediate
  function automatic logic [XLEN-1:0] enc_i(input opcode_e op, input int rd, input int rs1,
                                            input logic [IMM_W-1:0] imm);
    return {op, REG_AW'(rd), REG_AW'(rs1), imm};
  endfunction

  task automatic add_word(input int row, input logic [XLEN-1:0] w);
    prog[row][nwords[row]] = w;
    nwords[row]++;
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] t=%0t %s got %0h expected %0h", $time, sig, got, exp);
    row_err++;
  endtask

  task automatic report_issue(input string msg);
    $display("Error at t=%0t: %s", $time, msg);
    row_err++;
  endtask

  // Programs with expected r3 and retire counts
  task automatic build_table();
    logic [IMM_W-1:0] a;
    logic [IMM_W-1:0] b;
    logic [XLEN-1:0]  sum;
    int               n;
    for (int r = 0; r < NROWS; r++) begin
      nwords[r] = 0;
    end
    // ADDI then ADD
    a = IMM_W'(take_bits(IMM_W));
    b = IMM_W'(take_bits(IMM_W));
    row_name[0] = "add";
    add_word(0, enc_i(OP_ADDI, 1, 0, a));
    add_word(0, enc_i(OP_ADDI, 2, 0, b));
    add_word(0, enc_r(OP_ADD, 3, 1, 2));
    add_word(0, enc_r(OP_HALT, 0, 0, 0));
    exp_r3[0]  = sext20(a) + sext20(b);
    exp_ret[0] = 4;
    // SUB
    a = IMM_W'(take_bits(IMM_W));
    b = IMM_W'(take_bits(IMM_W));
    row_name[1] = "sub";
    add_word(1, enc_i(OP_ADDI, 1, 0, a));
    add_word(1, enc_i(OP_ADDI, 2, 0, b));
    add_word(1, enc_r(OP_SUB, 3, 1, 2));
    add_word(1, enc_r(OP_HALT, 0, 0, 0));
    exp_r3[1]  = sext20(a) - sext20(b);
    exp_ret[1] = 4;
    // AND, OR and XOR chained into r3
    a = IMM_W'(take_bits(IMM_W));
    b = IMM_W'(take_bits(IMM_W));
    row_name[2] = "logic";
    add_word(2, enc_i(OP_ADDI, 1, 0, a));
    add_word(2, enc_i(OP_ADDI, 2, 0, b));
    add_word(2, enc_r(OP_AND, 4, 1, 2));
    add_word(2, enc_r(OP_OR, 5, 1, 2));
    add_word(2, enc_r(OP_XOR, 3, 4, 5));
    add_word(2, enc_r(OP_HALT, 0, 0, 0));
    exp_r3[2]  = (sext20(a) & sext20(b)) ^ (sext20(a) | sext20(b));
    exp_ret[2] = 6;
    // SLL, amount wider than 5 bits
    a = IMM_W'(take_bits(IMM_W));
    b = IMM_W'(take_bits(8));
    row_name[3] = "sll";
    add_word(3, enc_i(OP_ADDI, 1, 0, a));
    add_word(3, enc_i(OP_ADDI, 2, 0, b));
    add_word(3, enc_r(OP_SLL, 3, 1, 2));
    add_word(3, enc_r(OP_HALT, 0, 0, 0));
    exp_r3[3]  = sext20(a) << b[4:0];
    exp_ret[3] = 4;
    // Write to r0 is dropped, r0 operand reads zero
    a = IMM_W'(take_bits(IMM_W)) | 20'h1;
    b = IMM_W'(take_bits(IMM_W));
    row_name[4] = "r0";
    add_word(4, enc_i(OP_ADDI, 0, 0, a));
    add_word(4, enc_i(OP_ADDI, 3, 0, b));
    add_word(4, enc_r(OP_ADD, 3, 3, 0));
    add_word(4, enc_r(OP_HALT, 0, 0, 0));
    exp_r3[4]  = sext20(b);
    exp_ret[4] = 4;
    // Countdown loop, body at pc 3..5, BNEZ back by two
    n = int'(take_bits(3)) + 2;
    b = IMM_W'(take_bits(IMM_W));
    row_name[5] = "loop";
    add_word(5, enc_i(OP_ADDI, 1, 0, IMM_W'(n)));
    add_word(5, enc_i(OP_ADDI, 2, 0, b));
    add_word(5, enc_i(OP_ADDI, 3, 0, 20'h0));
    add_word(5, enc_r(OP_ADD, 3, 3, 2));
    add_word(5, enc_i(OP_ADDI, 1, 1, 20'hfffff));
    add_word(5, enc_i(OP_BNEZ, 0, 1, 20'hffffe));
    add_word(5, enc_r(OP_HALT, 0, 0, 0));
    sum = '0;
    for (int k = 0; k < n; k++) begin
      sum = sum + sext20(b);
    end
    exp_r3[5]  = sum;
    exp_ret[5] = 3 + 3 * n + 1;
    // Reset, then per row loads, run and handshake, plus margin
    limit = 8 + 200;
    for (int r = 0; r < NROWS; r++) begin
      limit = limit + 2 * exp_ret[r] + 8 * nwords[r] + 8;
    end
  endtask

  // Four-phase load of one word
  task automatic load_word(input int row, input int idx);
    int waited;
    @(posedge clk);
    load_req_i  <= 1'b1;
    load_addr_i <= IMEM_AW'(idx);
    load_data_i <= prog[row][idx];
    @(negedge clk);
    if (load_ack_o) begin
      report_mismatch("load_ack_o", 32'(load_ack_o), 32'h0);
    end
    waited = 0;
    while (!load_ack_o && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!load_ack_o) begin
      report_issue($sformatf("load ack never rose for word %0d", idx));
    end
    @(posedge clk);
    load_req_i <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (load_ack_o && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (load_ack_o) begin
      report_issue($sformatf("load ack stayed high after req dropped, word %0d", idx));
    end
  endtask

  // Run one program and watch its trace up to HALT
  task automatic run_row(input int row);
    int                 retired;
    int                 req_cyc;
    int                 last_cyc;
    int                 waited;
    logic [IMEM_AW-1:0] seq_pc;
    logic [IMEM_AW-1:0] br_pc;
    logic               br_ok;
    logic               halt_seen;
    logic               r3_written;
    logic [XLEN-1:0]    last_wb_r3;
    insn_u              t;
    retired    = 0;
    last_cyc   = 0;
    seq_pc     = '0;
    br_pc      = '0;
    br_ok      = 1'b0;
    halt_seen  = 1'b0;
    r3_written = 1'b0;
    last_wb_r3 = '0;
    @(posedge clk);
    run_req_i <= 1'b1;
    @(negedge clk);
    req_cyc = cyc;
    while (!halt_seen) begin
      @(negedge clk);
      if (trace_valid_o) begin
        t = trace_insn_o;
        retired++;
        if (retired == 1 && cyc != req_cyc + 3) begin
          report_issue("first trace pulse not two cycles after run request");
        end
        if (retired > 1 && cyc - last_cyc != 2) begin
          report_mismatch("trace spacing", 32'(cyc - last_cyc), 32'd2);
        end
        last_cyc = cyc;
        if (trace_pc_o != seq_pc && !(br_ok && trace_pc_o == br_pc)) begin
          report_mismatch("trace_pc_o", 32'(trace_pc_o), 32'(seq_pc));
        end
        // Retired word must be the one loaded at that pc
        if (int'(trace_pc_o) < nwords[row]) begin
          if (trace_insn_o != prog[row][trace_pc_o]) begin
            report_mismatch("trace_insn_o", trace_insn_o, prog[row][trace_pc_o]);
          end
        end else begin
          report_issue("trace pc outside the loaded program");
        end
        // Next pc is sequential, or the target after a BNEZ
        seq_pc = trace_pc_o + 6'd1;
        br_pc  = trace_pc_o + t.i.imm[IMEM_AW-1:0];
        br_ok  = (t.r.op == OP_BNEZ);
        if (trace_wb_en_o && trace_wb_reg_o == REG_AW'(3)) begin
          shadow_r3  = trace_wb_data_o;
          last_wb_r3 = trace_wb_data_o;
          r3_written = 1'b1;
        end
        if (t.r.op == OP_HALT) begin
          halt_seen = 1'b1;
          if (trace_wb_en_o) begin
            report_mismatch("trace_wb_en_o", 32'(trace_wb_en_o), 32'h0);
          end
          if (!run_ack_o) begin
            report_mismatch("run_ack_o", 32'(run_ack_o), 32'h1);
          end
        end else if (run_ack_o) begin
          report_issue("run ack rose before HALT retired");
        end
      end else if (run_ack_o) begin
        report_issue("run ack rose before HALT retired");
      end
    end
    if (retired != exp_ret[row]) begin
      report_mismatch("retired count", 32'(retired), 32'(exp_ret[row]));
    end
    if (shadow_r3 != exp_r3[row]) begin
      report_mismatch("shadow r3", shadow_r3, exp_r3[row]);
    end
    if (!r3_written) begin
      report_issue("no trace writeback to r3 in this run");
    end else if (last_wb_r3 != exp_r3[row]) begin
      report_mismatch("trace_wb_data_o r3", last_wb_r3, exp_r3[row]);
    end
    @(posedge clk);
    run_req_i <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (run_ack_o && waited < ACK_WAIT) begin
      if (trace_valid_o) begin
        report_issue("trace pulse after HALT");
      end
      @(negedge clk);
      waited++;
    end
    if (run_ack_o) begin
      report_issue("run ack stayed high after run req dropped");
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    load_req_i  = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    run_req_i   = 1'b0;
    cyc         = 0;
    errors      = 0;
    rows_ok     = 0;
    row_err     = 0;
    shadow_r3   = '0;
    lfsr        = 32'd70631;
    build_table();
    repeat (8) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    if (load_ack_o || run_ack_o || trace_valid_o) begin
      report_issue("handshake or trace outputs active after reset");
    end
    errors = row_err;
    for (int r = 0; r < NROWS; r++) begin
      row_err = 0;
      for (int k = 0; k < nwords[r]; k++) begin
        load_word(r, k);
      end
      run_row(r);
      if (row_err == 0) begin
        rows_ok++;
        $display("Row %0d (%s): ok, r3 %0h", r, row_name[r], exp_r3[r]);
      end else begin
        $display("Row %0d (%s): %0d failing checks", r, row_name[r], row_err);
      end
      errors = errors + row_err;
    end
    $display("Rows passed %0d of %0d, failing checks %0d", rows_ok, NROWS, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
